//--- Bender.yml
package:
  name: ex_unit

sources:
  - files:
      - design/ex_pkg.sv
      - design/ex_opnd_sel.sv
      - design/ex_alu.sv
      - design/ex_branch_resolve.sv
      - design/ex_hold_reg.sv
      - design/ex_ctrl.sv
      - design/ex_unit.sv
  - target: test
    files:
      - testbench/ex_unit_props.sv
      - testbench/ex_unit_tb.sv

//--- design/ex_alu.sv
// combinational alu with logic ops, shifts and signed and unsigned compares
`timescale 1ns/1ps

module ex_alu
(
	input  logic [ex_pkg::XLEN-1:0] opa,
	input  logic [ex_pkg::XLEN-1:0] opb,
	input  ex_pkg::alu_func_e       func,
	output logic [ex_pkg::XLEN-1:0] result
);

	localparam int SH_W = $clog2(ex_pkg::XLEN); // 6 bits of shift amount

	logic [SH_W-1:0] shamt;
	logic            lt_s;   // signed less than
	logic            lt_u;   // unsigned less than
	logic            eq;

	// signed compare from the sign bits
	function automatic logic signed_lt(input logic [ex_pkg::XLEN-1:0] a,
		input logic [ex_pkg::XLEN-1:0] b);
		if (a[ex_pkg::XLEN-1] == b[ex_pkg::XLEN-1])
			signed_lt = (a < b);              // same sign, unsigned order holds
		else
			signed_lt = a[ex_pkg::XLEN-1];    // negative one is smaller
	endfunction

	assign shamt = opb[SH_W-1:0];
	assign lt_s  = signed_lt(opa, opb);
	assign lt_u  = (opa < opb);
	assign eq    = (opa == opb);

	//////////////////////////////
	// function mux
	//////////////////////////////
	always_comb
	begin
		case (func)
			ex_pkg::ADDQ:   result = opa + opb;
			ex_pkg::SUBQ:   result = opa - opb;
			ex_pkg::AND:    result = opa & opb;
			ex_pkg::BIC:    result = opa & ~opb;
			ex_pkg::BIS:    result = opa | opb;
			ex_pkg::ORNOT:  result = opa | ~opb;
			ex_pkg::XOR:    result = opa ^ opb;
			ex_pkg::EQV:    result = opa ^ ~opb;
			ex_pkg::SRL:    result = opa >> shamt;
			ex_pkg::SLL:    result = opa << shamt;
			ex_pkg::SRA:    result = $signed(opa) >>> shamt; // sign fill
			// compares give 0 or 1
			ex_pkg::CMPULT: result = {{(ex_pkg::XLEN-1){1'b0}}, lt_u};
			ex_pkg::CMPEQ:  result = {{(ex_pkg::XLEN-1){1'b0}}, eq};
			ex_pkg::CMPULE: result = {{(ex_pkg::XLEN-1){1'b0}}, lt_u | eq};
			ex_pkg::CMPLT:  result = {{(ex_pkg::XLEN-1){1'b0}}, lt_s};
			ex_pkg::CMPLE:  result = {{(ex_pkg::XLEN-1){1'b0}}, lt_s | eq};
			default:        result = ex_pkg::ILLEGAL_RESULT; // unused code
		endcase
	end

endmodule

//--- design/ex_branch_resolve.sv
// branch condition test, taken decision, mispredict check and write-back select
`timescale 1ns/1ps

module ex_branch_resolve
(
	input  logic [ex_pkg::XLEN-1:0]     prf_pra,          // value under test
	input  logic [ex_pkg::ILEN-1:0]     rs_ir,
	input  logic [ex_pkg::XLEN-1:0]     rs_npc,           // link value
	input  logic                        rs_cond_branch,
	input  logic                        rs_uncond_branch,
	input  logic                        rs_branch_taken,  // predicted direction
	input  logic [ex_pkg::XLEN-1:0]     rs_pred_addr,     // predicted target
	input  logic [ex_pkg::AR_IDX_W-1:0] rs_dest_ar_idx,
	input  logic [ex_pkg::XLEN-1:0]     alu_result,       // computed target
	output logic                        take_branch,
	output logic                        mispredict,
	output logic [ex_pkg::XLEN-1:0]     wb_value
);

	logic [2:0] cond_code;
	logic       cond_raw;
	logic       cond;
	logic       is_neg;
	logic       is_zero;

	assign cond_code = rs_ir[ex_pkg::BRCOND_LSB +: 3];
	assign is_neg    = prf_pra[ex_pkg::XLEN-1];
	assign is_zero   = (prf_pra == '0);

	//////////////////////////////
	// condition
	//////////////////////////////
	always_comb
	begin
		case (cond_code[1:0])
			2'b00:   cond_raw = ~prf_pra[0];       // low bit clear
			2'b01:   cond_raw = is_zero;
			2'b10:   cond_raw = is_neg;
			default: cond_raw = is_neg | is_zero;  // le zero
		endcase
	end

	assign cond        = cond_raw ^ cond_code[2]; // top bit flips the sense
	assign take_branch = rs_uncond_branch | (rs_cond_branch & cond);

	// wrong direction or wrong target
	always_comb
	begin
		mispredict = 1'b0;
		if (rs_cond_branch && (rs_branch_taken != take_branch))
			mispredict = 1'b1;
		if (rs_uncond_branch && (rs_pred_addr != alu_result))
			mispredict = 1'b1;
	end

	// value for the register file
	always_comb
	begin
		if (rs_dest_ar_idx == ex_pkg::ZERO_REG)
			wb_value = '0;
		else if (take_branch)
			wb_value = rs_npc;   // return address
		else
			wb_value = alu_result;
	end

endmodule

//--- design/ex_ctrl.sv
// lane acceptance, stall hold, availability and registered completion flags
`timescale 1ns/1ps

module ex_ctrl
#(
	parameter int NUM_LANES = 2
)
(
	input  logic                 clock,
	input  logic                 rst_n,
	input  logic [NUM_LANES-1:0] rs_valid_inst,
	input  logic                 cdb_stall,        // cdb cannot take results
	input  logic [NUM_LANES-1:0] mispredict,
	input  logic [NUM_LANES-1:0] take_branch,
	output logic [NUM_LANES-1:0] rs_alu_avail,
	output logic [NUM_LANES-1:0] lane_load,        // to the hold registers
	output logic [NUM_LANES-1:0] cdb_complete,
	output logic [NUM_LANES-1:0] prf_write_enable,
	output logic [NUM_LANES-1:0] cdb_exception,
	output logic [NUM_LANES-1:0] cdb_actual_taken
);

	logic [NUM_LANES-1:0] complete_q;
	logic [NUM_LANES-1:0] exception_q;
	logic [NUM_LANES-1:0] taken_q;
	logic [NUM_LANES-1:0] hold;

	//////////////////////////////
	// acceptance
	//////////////////////////////
	// a lane holds only while its result waits on a stalled cdb
	assign hold         = {NUM_LANES{cdb_stall}} & complete_q;
	assign rs_alu_avail = ~hold;
	assign lane_load    = rs_valid_inst & rs_alu_avail;

	// completion flags per lane
	always_ff @(posedge clock)
	begin
		if (!rst_n)
		begin
			complete_q  <= '0;
			exception_q <= '0;
			taken_q     <= '0;
		end
		else
		begin
			for (int i = 0; i < NUM_LANES; i++)
			begin
				if (!hold[i])
				begin
					complete_q[i]  <= lane_load[i];   // drops when idle
					exception_q[i] <= lane_load[i] & mispredict[i];
					taken_q[i]     <= lane_load[i] & take_branch[i];
				end
			end
		end
	end

	assign cdb_complete     = complete_q;
	assign prf_write_enable = complete_q;  // every alu op writes back
	assign cdb_exception    = exception_q;
	assign cdb_actual_taken = taken_q;

endmodule

//--- design/ex_hold_reg.sv
// load-enabled output register for one lane payload of any packed type
`timescale 1ns/1ps

module ex_hold_reg
#(
	parameter type payload_t = logic
)
(
	input  logic     clock,
	input  logic     rst_n,
	input  logic     load,  // new instruction accepted
	input  payload_t d,
	output payload_t q
);

	payload_t q_r;

	//////////////////////////////
	// register
	//////////////////////////////
	always_ff @(posedge clock)
	begin
		if (!rst_n)
			q_r <= '0;
		else if (load)
			q_r <= d;
		// otherwise keep, covers the stall hold
	end

	assign q = q_r;

endmodule

//--- design/ex_opnd_sel.sv
// per-lane operand a and b multiplexers with immediate extraction
`timescale 1ns/1ps

module ex_opnd_sel
(
	input  logic [ex_pkg::XLEN-1:0] rs_npc,        // pc + 4
	input  logic [ex_pkg::ILEN-1:0] rs_ir,         // raw instruction
	input  logic [ex_pkg::XLEN-1:0] prf_pra,       // register a value
	input  logic [ex_pkg::XLEN-1:0] prf_prb,       // register b value
	input  ex_pkg::opa_sel_e        rs_opa_select,
	input  ex_pkg::opb_sel_e        rs_opb_select,
	input  logic                    rs_cond_branch,
	output logic [ex_pkg::XLEN-1:0] opa,
	output logic [ex_pkg::XLEN-1:0] opb
);

	logic [ex_pkg::XLEN-1:0] mem_disp;
	logic [ex_pkg::XLEN-1:0] br_disp;
	logic [ex_pkg::XLEN-1:0] alu_imm;
	logic                    ra_is_zero;
	logic                    rb_is_zero;

	//////////////////////////////
	// immediates
	//////////////////////////////
	// sign extended memory displacement
	assign mem_disp = {{(ex_pkg::XLEN-ex_pkg::MEM_DISP_W){rs_ir[ex_pkg::MEM_DISP_W-1]}},
		rs_ir[ex_pkg::MEM_DISP_W-1:0]};
	// branch displacement counts words so shift by two
	assign br_disp = {{(ex_pkg::XLEN-ex_pkg::BR_DISP_W-2){rs_ir[ex_pkg::BR_DISP_W-1]}},
		rs_ir[ex_pkg::BR_DISP_W-1:0], 2'b00};
	assign alu_imm = {{(ex_pkg::XLEN-ex_pkg::ALU_IMM_W){1'b0}},
		rs_ir[ex_pkg::ALU_IMM_LSB +: ex_pkg::ALU_IMM_W]}; // zero extended literal

	assign ra_is_zero = (rs_ir[ex_pkg::RA_LSB +: ex_pkg::AR_IDX_W] == ex_pkg::ZERO_REG);
	assign rb_is_zero = (rs_ir[ex_pkg::RB_LSB +: ex_pkg::AR_IDX_W] == ex_pkg::ZERO_REG);

	//////////////////////////////
	// operand a
	//////////////////////////////
	always_comb
	begin
		case (rs_opa_select)
			ex_pkg::REGA:
			begin
				if (rs_cond_branch)
					opa = rs_npc;   // alu forms the target
				else if (ra_is_zero)
					opa = '0;
				else
					opa = prf_pra;
			end
			ex_pkg::MEM_DISP: opa = mem_disp;
			ex_pkg::NPC:      opa = rs_npc;
			default:          opa = ~ex_pkg::XLEN'(3); // NOT3
		endcase
	end

	// operand b
	always_comb
	begin
		case (rs_opb_select)
			ex_pkg::REGB:    opb = rb_is_zero ? '0 : prf_prb;
			ex_pkg::ALU_IMM: opb = alu_imm;
			ex_pkg::BR_DISP: opb = br_disp;
			default:         opb = ex_pkg::ILLEGAL_RESULT; // bad select shows up here
		endcase
	end

endmodule

//--- design/ex_pkg.sv
// shared widths, alu function codes, operand select codes and instruction field positions
package ex_pkg;

	//////////////////////////////
	// widths
	//////////////////////////////
	parameter int XLEN     = 64; // datapath width
	parameter int ILEN     = 32; // instruction word
	parameter int AR_IDX_W = 5;  // architectural register index

	// r31 always reads as zero
	parameter logic [AR_IDX_W-1:0] ZERO_REG = 5'd31;

	//////////////////////////////
	// alu function codes
	//////////////////////////////
	// 5'h0b stays free, it held the multiply
	typedef enum logic [4:0] {
		ADDQ   = 5'h00,
		SUBQ   = 5'h01,
		AND    = 5'h02,
		BIC    = 5'h03, // and with complement
		BIS    = 5'h04, // plain or
		ORNOT  = 5'h05,
		XOR    = 5'h06,
		EQV    = 5'h07, // xor with complement
		SRL    = 5'h08,
		SLL    = 5'h09,
		SRA    = 5'h0a,
		CMPULT = 5'h0c,
		CMPEQ  = 5'h0d,
		CMPULE = 5'h0e,
		CMPLT  = 5'h0f,
		CMPLE  = 5'h10
	} alu_func_e;

	//////////////////////////////
	// operand select codes
	//////////////////////////////
	typedef enum logic [1:0] {
		REGA     = 2'd0, // npc instead for cond branches
		MEM_DISP = 2'd1,
		NPC      = 2'd2,
		NOT3     = 2'd3  // ~3 mask for aligned addresses
	} opa_sel_e;

	typedef enum logic [1:0] {
		REGB    = 2'd0,
		ALU_IMM = 2'd1,
		BR_DISP = 2'd2  // code 3 unused
	} opb_sel_e;

	// instruction field positions
	parameter int RA_LSB      = 21; // ra in [25:21]
	parameter int RB_LSB      = 16; // rb in [20:16]
	parameter int MEM_DISP_W  = 16; // memory displacement [15:0]
	parameter int BR_DISP_W   = 21; // branch displacement [20:0]
	parameter int ALU_IMM_LSB = 13; // literal in [20:13]
	parameter int ALU_IMM_W   = 8;
	parameter int BRCOND_LSB  = 26; // branch condition in [28:26]

	// marker for an undefined function or select code
	parameter logic [XLEN-1:0] ILLEGAL_RESULT = 64'hdeadbeefbaadbeef;

endpackage

//--- design/ex_unit.sv
// integer execute unit top level with per-lane datapath and payload types
`timescale 1ns/1ps

module ex_unit
#(
	parameter int NUM_LANES = 2,
	parameter int PR_IDX_W  = 7   // physical tag width
)
(
	input  logic                                           clock,
	input  logic                                           rst_n,
	// reservation station
	input  logic [NUM_LANES-1:0]                           rs_valid_inst,
	input  logic [NUM_LANES-1:0][ex_pkg::XLEN-1:0]         rs_npc,
	input  logic [NUM_LANES-1:0][ex_pkg::ILEN-1:0]         rs_ir,
	input  ex_pkg::opa_sel_e [NUM_LANES-1:0]               rs_opa_select,
	input  ex_pkg::opb_sel_e [NUM_LANES-1:0]               rs_opb_select,
	input  ex_pkg::alu_func_e [NUM_LANES-1:0]              rs_alu_func,
	input  logic [NUM_LANES-1:0]                           rs_cond_branch,
	input  logic [NUM_LANES-1:0]                           rs_uncond_branch,
	input  logic [NUM_LANES-1:0]                           rs_branch_taken,
	input  logic [NUM_LANES-1:0][ex_pkg::XLEN-1:0]         rs_pred_addr,
	input  logic [NUM_LANES-1:0][ex_pkg::AR_IDX_W-1:0]     rs_dest_ar_idx,
	input  logic [NUM_LANES-1:0][PR_IDX_W-1:0]             rs_dest_pr_idx,
	// register file reads
	input  logic [NUM_LANES-1:0][ex_pkg::XLEN-1:0]         prf_pra,
	input  logic [NUM_LANES-1:0][ex_pkg::XLEN-1:0]         prf_prb,
	input  logic                                           cdb_stall,
	// register file write
	output logic [NUM_LANES-1:0][ex_pkg::XLEN-1:0]         prf_result,
	output logic [NUM_LANES-1:0]                           prf_write_enable,
	output logic [NUM_LANES-1:0][PR_IDX_W-1:0]             cdb_prf_dest_pr_idx,
	// cdb
	output logic [NUM_LANES-1:0]                           cdb_complete,
	output logic [NUM_LANES-1:0][ex_pkg::AR_IDX_W-1:0]     cdb_dest_ar_idx,
	output logic [NUM_LANES-1:0]                           cdb_exception,
	output logic [NUM_LANES-1:0][ex_pkg::XLEN-1:0]         cdb_actual_addr,
	output logic [NUM_LANES-1:0]                           cdb_actual_taken,
	output logic [NUM_LANES-1:0]                           rs_alu_avail
);

	//////////////////////////////
	// payload types
	//////////////////////////////
	typedef struct packed {
		logic [ex_pkg::XLEN-1:0] result;
		logic [PR_IDX_W-1:0]     pr_idx;
	} prf_payload_t;

	typedef struct packed {
		logic [ex_pkg::AR_IDX_W-1:0] ar_idx;
		logic [ex_pkg::XLEN-1:0]     actual_addr;
	} cdb_payload_t;

	logic [NUM_LANES-1:0] lane_load;
	logic [NUM_LANES-1:0] take_branch;
	logic [NUM_LANES-1:0] mispredict;

	// shared control across lanes
	ex_ctrl #(.NUM_LANES(NUM_LANES)) i_ctrl (
		.clock            (clock),
		.rst_n            (rst_n),
		.rs_valid_inst    (rs_valid_inst),
		.cdb_stall        (cdb_stall),
		.mispredict       (mispredict),
		.take_branch      (take_branch),
		.rs_alu_avail     (rs_alu_avail),
		.lane_load        (lane_load),
		.cdb_complete     (cdb_complete),
		.prf_write_enable (prf_write_enable),
		.cdb_exception    (cdb_exception),
		.cdb_actual_taken (cdb_actual_taken)
	);

	//////////////////////////////
	// lanes
	//////////////////////////////
	for (genvar i = 0; i < NUM_LANES; i++)
	begin : g_lane
		logic [ex_pkg::XLEN-1:0] opa;
		logic [ex_pkg::XLEN-1:0] opb;
		logic [ex_pkg::XLEN-1:0] alu_result;
		logic [ex_pkg::XLEN-1:0] wb_value;
		prf_payload_t            prf_d;
		prf_payload_t            prf_q;
		cdb_payload_t            cdb_d;
		cdb_payload_t            cdb_q;

		ex_opnd_sel i_opnd_sel (
			.rs_npc         (rs_npc[i]),
			.rs_ir          (rs_ir[i]),
			.prf_pra        (prf_pra[i]),
			.prf_prb        (prf_prb[i]),
			.rs_opa_select  (rs_opa_select[i]),
			.rs_opb_select  (rs_opb_select[i]),
			.rs_cond_branch (rs_cond_branch[i]),
			.opa            (opa),
			.opb            (opb)
		);

		ex_alu i_alu (
			.opa    (opa),
			.opb    (opb),
			.func   (rs_alu_func[i]),
			.result (alu_result)
		);

		ex_branch_resolve i_br (
			.prf_pra          (prf_pra[i]),   // condition always on reg a
			.rs_ir            (rs_ir[i]),
			.rs_npc           (rs_npc[i]),
			.rs_cond_branch   (rs_cond_branch[i]),
			.rs_uncond_branch (rs_uncond_branch[i]),
			.rs_branch_taken  (rs_branch_taken[i]),
			.rs_pred_addr     (rs_pred_addr[i]),
			.rs_dest_ar_idx   (rs_dest_ar_idx[i]),
			.alu_result       (alu_result),
			.take_branch      (take_branch[i]),
			.mispredict       (mispredict[i]),
			.wb_value         (wb_value)
		);

		assign prf_d = '{result: wb_value, pr_idx: rs_dest_pr_idx[i]};
		assign cdb_d = '{ar_idx: rs_dest_ar_idx[i], actual_addr: alu_result};

		// register file side
		ex_hold_reg #(.payload_t(prf_payload_t)) i_prf_reg (
			.clock (clock),
			.rst_n (rst_n),
			.load  (lane_load[i]),
			.d     (prf_d),
			.q     (prf_q)
		);

		// cdb side
		ex_hold_reg #(.payload_t(cdb_payload_t)) i_cdb_reg (
			.clock (clock),
			.rst_n (rst_n),
			.load  (lane_load[i]),
			.d     (cdb_d),
			.q     (cdb_q)
		);

		assign prf_result[i]          = prf_q.result;
		assign cdb_prf_dest_pr_idx[i] = prf_q.pr_idx;
		assign cdb_dest_ar_idx[i]     = cdb_q.ar_idx;
		assign cdb_actual_addr[i]     = cdb_q.actual_addr;
	end

endmodule

//--- ex_unit.f
design/ex_pkg.sv
design/ex_opnd_sel.sv
design/ex_alu.sv
design/ex_branch_resolve.sv
design/ex_hold_reg.sv
design/ex_ctrl.sv
design/ex_unit.sv
testbench/ex_unit_props.sv
testbench/ex_unit_tb.sv

//--- testbench/ex_unit_props.sv
// concurrent properties on the execute unit ports, bound into the top level
`timescale 1ns/1ps

module ex_unit_props
#(
	parameter int NUM_LANES = 2,
	parameter int PR_IDX_W  = 7
)
(
	input logic                                       clock,
	input logic                                       rst_n,
	input logic                                       cdb_stall,
	input logic [NUM_LANES-1:0]                       rs_valid_inst,
	input logic [NUM_LANES-1:0]                       rs_alu_avail,
	input logic [NUM_LANES-1:0]                       cdb_complete,
	input logic [NUM_LANES-1:0]                       prf_write_enable,
	input logic [NUM_LANES-1:0]                       cdb_exception,
	input logic [NUM_LANES-1:0]                       cdb_actual_taken,
	input logic [NUM_LANES-1:0][ex_pkg::XLEN-1:0]     prf_result,
	input logic [NUM_LANES-1:0][ex_pkg::XLEN-1:0]     cdb_actual_addr,
	input logic [NUM_LANES-1:0][ex_pkg::AR_IDX_W-1:0] cdb_dest_ar_idx,
	input logic [NUM_LANES-1:0][PR_IDX_W-1:0]         cdb_prf_dest_pr_idx
);

	// write enable mirrors completion
	a_we_eq_complete: assert property (@(posedge clock) prf_write_enable == cdb_complete)
		else $error("prf_write_enable differs from cdb_complete");

	// idle control one cycle into reset
	a_reset_idle: assert property (@(posedge clock) !rst_n |=> (cdb_complete == 0 &&
		cdb_exception == 0 && cdb_actual_taken == 0 && rs_alu_avail == '1))
		else $error("control outputs not idle after reset");

	//////////////////////////////
	// per lane
	//////////////////////////////
	for (genvar i = 0; i < NUM_LANES; i++)
	begin : g_lane
		a_stall_hold: assert property (@(posedge clock) disable iff (!rst_n)
			(cdb_stall && cdb_complete[i]) |=> (cdb_complete[i] && $stable(prf_result[i]) &&
			$stable(cdb_actual_addr[i]) && $stable(cdb_dest_ar_idx[i]) &&
			$stable(cdb_prf_dest_pr_idx[i]) && $stable(cdb_exception[i]) &&
			$stable(cdb_actual_taken[i])))
			else $error("lane %0d outputs moved under stall", i);

		a_no_issue_unavail: assert property (@(posedge clock) disable iff (!rst_n)
			!(rs_valid_inst[i] && !rs_alu_avail[i]))
			else $error("lane %0d presented while unavailable", i);
	end

endmodule

bind ex_unit ex_unit_props #(.NUM_LANES(NUM_LANES), .PR_IDX_W(PR_IDX_W)) i_props (.*);

//--- testbench/ex_unit_tb.sv
// testbench for the execute unit with lcg stimulus, reference model and per-lane checking
`timescale 1ns/1ps

module ex_unit_tb;

	localparam int LANES        = 2;
	localparam int PRW          = 7;
	localparam int TOTAL_ISSUES = LANES * (64 + 64 + 64 + 48 + 160); // issue slots over all tests
	localparam int CYCLE_LIMIT  = 4 * TOTAL_ISSUES + 200;

	typedef struct packed {
		logic [63:0] npc;
		logic [31:0] ir;
		logic [1:0]  opa_sel;
		logic [1:0]  opb_sel;
		logic [4:0]  func;
		logic        cond_br;
		logic        uncond_br;
		logic        pred_taken;
		logic [63:0] pred_addr;
		logic [4:0]  dest_ar;
		logic [PRW-1:0] dest_pr;
		logic [63:0] pra;
		logic [63:0] prb;
	} inst_t;

	typedef struct packed {
		logic [63:0]    result;
		logic [PRW-1:0] pr;
		logic [4:0]     ar;
		logic [63:0]    addr;
		logic           exc;
		logic           taken;
	} exp_t;

	logic clock = 1'b0;
	logic rst_n;
	logic [LANES-1:0] rs_valid_inst, rs_cond_branch, rs_uncond_branch, rs_branch_taken;
	logic [LANES-1:0][63:0] rs_npc, rs_pred_addr, prf_pra, prf_prb;
	logic [LANES-1:0][31:0] rs_ir;
	ex_pkg::opa_sel_e [LANES-1:0]  rs_opa_select;
	ex_pkg::opb_sel_e [LANES-1:0]  rs_opb_select;
	ex_pkg::alu_func_e [LANES-1:0] rs_alu_func;
	logic [LANES-1:0][4:0]     rs_dest_ar_idx;
	logic [LANES-1:0][PRW-1:0] rs_dest_pr_idx;
	logic cdb_stall;
	logic [LANES-1:0][63:0]    prf_result, cdb_actual_addr;
	logic [LANES-1:0][PRW-1:0] cdb_prf_dest_pr_idx;
	logic [LANES-1:0][4:0]     cdb_dest_ar_idx;
	logic [LANES-1:0] prf_write_enable, cdb_complete, cdb_exception, cdb_actual_taken, rs_alu_avail;

	logic [31:0] seed = 32'd30;
	int          cycles = 0;
	int          checks = 0;
	int          errors = 0;
	exp_t        exp_q[LANES][$];

	ex_unit i_dut (.*);

	always #10 clock = ~clock; // 20 ns period

	// lcg, upper half of two steps since the low bits cycle fast
	function automatic logic [31:0] rnd();
		logic [15:0] hi;
		seed = seed * 32'd1103515245 + 32'd12345;
		hi   = seed[31:16];
		seed = seed * 32'd1103515245 + 32'd12345;
		return {hi, seed[31:16]};
	endfunction

	// index 0..15 onto the function codes, 5'h0b skipped
	function automatic logic [4:0] func_code(input int idx);
		return (idx < 11) ? 5'(idx) : 5'(idx + 1);
	endfunction

	//////////////////////////////
	// reference model
	//////////////////////////////
	function automatic exp_t ref_model(input inst_t in);
		exp_t        e;
		logic [63:0] a, b, alu, mdisp, bdisp, imm;
		logic [4:0]  ra, rb;
		logic [2:0]  cc;
		logic        c, taken;
		ra    = in.ir[ex_pkg::RA_LSB +: 5];
		rb    = in.ir[ex_pkg::RB_LSB +: 5];
		mdisp = 64'(signed'(in.ir[15:0]));
		bdisp = 64'(signed'(in.ir[20:0])) * 4;
		imm   = 64'(in.ir[ex_pkg::ALU_IMM_LSB +: 8]);
		case (in.opa_sel)
			2'd0:    a = in.cond_br ? in.npc : ((ra == 5'd31) ? 64'd0 : in.pra);
			2'd1:    a = mdisp;
			2'd2:    a = in.npc;
			default: a = 64'hffff_ffff_ffff_fffc;
		endcase
		case (in.opb_sel)
			2'd0:    b = (rb == 5'd31) ? 64'd0 : in.prb;
			2'd1:    b = imm;
			default: b = bdisp;
		endcase
		case (in.func)
			5'h00: alu = a + b;
			5'h01: alu = a - b;
			5'h02: alu = a & b;
			5'h03: alu = a & ~b;
			5'h04: alu = a | b;
			5'h05: alu = a | ~b;
			5'h06: alu = a ^ b;
			5'h07: alu = ~(a ^ b);
			5'h08: alu = a >> b[5:0];
			5'h09: alu = a << b[5:0];
			5'h0a: alu = $signed(a) >>> b[5:0];
			5'h0c: alu = 64'(a < b);
			5'h0d: alu = 64'(a == b);
			5'h0e: alu = 64'(a <= b);
			5'h0f: alu = 64'($signed(a) < $signed(b));
			5'h10: alu = 64'($signed(a) <= $signed(b));
			default: alu = ex_pkg::ILLEGAL_RESULT;
		endcase
		cc = in.ir[ex_pkg::BRCOND_LSB +: 3];
		case (cc[1:0])
			2'b00:   c = !in.pra[0];
			2'b01:   c = (in.pra == 0);
			2'b10:   c = ($signed(in.pra) < 0);
			default: c = ($signed(in.pra) <= 0);
		endcase
		c       = c ^ cc[2];
		taken   = in.uncond_br || (in.cond_br && c);
		e.taken = taken;
		e.exc   = (in.cond_br && in.pred_taken != taken) || (in.uncond_br && in.pred_addr != alu);
		e.result = (in.dest_ar == 5'd31) ? 64'd0 : (taken ? in.npc : alu);
		e.pr    = in.dest_pr;
		e.ar    = in.dest_ar;
		e.addr  = alu;
		return e;
	endfunction

	task automatic check_val(input string name, input int lane, input logic [63:0] got,
		input logic [63:0] exp);
		checks++;
		assert (got === exp)
		else
		begin
			$display("[FAIL] lane %0d %s got %h expected %h", lane, name, got, exp);
			errors++;
		end
	endtask

	//////////////////////////////
	// comparison process
	//////////////////////////////
	// negedge sees the values that the next rising edge acts on
	always @(negedge clock)
	begin
		exp_t  e;
		inst_t in;
		logic  pending;
		if (rst_n)
		begin
			for (int l = 0; l < LANES; l++)
			begin
				pending = (exp_q[l].size() > 0); // accepted, cdb has not taken it yet
				check_val("cdb_complete", l, 64'(cdb_complete[l]), 64'(pending));
				check_val("prf_write_enable", l, 64'(prf_write_enable[l]), 64'(pending));
				check_val("rs_alu_avail", l, 64'(rs_alu_avail[l]),
					64'(!(cdb_stall && pending)));
				checks++;
				assert (!(rs_valid_inst[l] && !rs_alu_avail[l]))
				else
				begin
					$display("lane %0d presented an instruction while unavailable", l);
					errors++;
				end
				if (pending)
				begin
					e = exp_q[l][0];   // same values all through a stall
					check_val("prf_result", l, prf_result[l], e.result);
					check_val("cdb_prf_dest_pr_idx", l, 64'(cdb_prf_dest_pr_idx[l]), 64'(e.pr));
					check_val("cdb_dest_ar_idx", l, 64'(cdb_dest_ar_idx[l]), 64'(e.ar));
					check_val("cdb_actual_addr", l, cdb_actual_addr[l], e.addr);
					check_val("cdb_exception", l, 64'(cdb_exception[l]), 64'(e.exc));
					check_val("cdb_actual_taken", l, 64'(cdb_actual_taken[l]), 64'(e.taken));
					if (!cdb_stall)
						e = exp_q[l].pop_front(); // taken by the cdb at the coming edge
				end
				if (rs_valid_inst[l] && rs_alu_avail[l]) // accepted at the coming edge
				begin
					in = '{rs_npc[l], rs_ir[l], rs_opa_select[l], rs_opb_select[l], rs_alu_func[l],
						rs_cond_branch[l], rs_uncond_branch[l], rs_branch_taken[l], rs_pred_addr[l],
						rs_dest_ar_idx[l], rs_dest_pr_idx[l], prf_pra[l], prf_prb[l]};
					exp_q[l].push_back(ref_model(in));
				end
			end
		end
	end

	always @(posedge clock)
	begin
		cycles++;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("timeout after %0d cycles with completions still missing", cycles);
			$display(">>> FAIL");
			$finish;
		end
	end

	// one lane's instruction for the given test kind
	task automatic drive_lane(input int l, input int kind, input int step);
		logic [31:0] ir;
		logic [63:0] npc;
		logic [63:0] pra;
		int          k;
		ir  = rnd();
		npc = {rnd(), rnd()} & ~64'd3;
		pra = {rnd(), rnd()};
		k   = (kind == 6) ? 2 + int'(rnd() % 4) : kind;
		rs_npc[l]           <= npc;
		prf_pra[l]          <= pra;
		prf_prb[l]          <= {rnd(), rnd()};
		rs_pred_addr[l]     <= {rnd(), rnd()};
		rs_branch_taken[l]  <= (rnd() % 2 != 0);
		rs_dest_ar_idx[l]   <= (rnd() % 4 == 0) ? 5'd31 : 5'(rnd());
		rs_dest_pr_idx[l]   <= PRW'(rnd());
		rs_cond_branch[l]   <= 1'b0;
		rs_uncond_branch[l] <= 1'b0;
		rs_opa_select[l]    <= ex_pkg::REGA;
		rs_opb_select[l]    <= ex_pkg::REGB;
		rs_alu_func[l]      <= ex_pkg::alu_func_e'(func_code(int'(rnd() % 16)));
		case (k)
			2:
			begin
				rs_alu_func[l] <= ex_pkg::alu_func_e'(func_code((step + l) % 16));
				if (rnd() % 4 == 0)
				begin
					ir[20:16] = ir[25:21];   // equal operands for the compares
					prf_prb[l] <= pra;
				end
			end
			3:
			begin
				if (rnd() % 4 == 0)
					ir[25:21] = 5'd31;   // zero reg as source
				if (rnd() % 4 == 0)
					ir[20:16] = 5'd31;
				rs_opa_select[l] <= ex_pkg::opa_sel_e'(rnd() % 4);
				rs_opb_select[l] <= ex_pkg::opb_sel_e'(rnd() % 3);
			end
			4:
			begin
				ir[28:26] = 3'(step);    // walk all eight conditions
				rs_cond_branch[l] <= 1'b1;
				rs_opb_select[l]  <= ex_pkg::BR_DISP;
				rs_alu_func[l]    <= ex_pkg::ADDQ;
				case (rnd() % 4)
					0: prf_pra[l] <= 64'd0;
					1: prf_pra[l] <= {1'b1, 31'(rnd()), rnd()};
					2: prf_pra[l] <= 64'(rnd() % 8);
					default: ;
				endcase
			end
			5:
			begin
				rs_uncond_branch[l] <= 1'b1;
				rs_opa_select[l]    <= ex_pkg::NPC;
				rs_opb_select[l]    <= ex_pkg::BR_DISP;
				rs_alu_func[l]      <= ex_pkg::ADDQ;
				if (rnd() % 2)
					rs_pred_addr[l] <= npc + {{41{ir[20]}}, ir[20:0], 2'b00}; // right target
			end
			default: ;
		endcase
		rs_ir[l] <= ir;
	endtask

	task automatic run_test(input int kind, input int n_cycles, input string name);
		int   err0, chk0;
		logic stall;
		logic pend;
		err0 = errors;
		chk0 = checks;
		for (int s = 0; s < n_cycles; s++)
		begin
			@(posedge clock);
			stall = (kind == 6) && (rnd() % 3 == 0);
			cdb_stall <= stall;
			for (int l = 0; l < LANES; l++)
			begin
				pend = (exp_q[l].size() > 0); // completion pending after this edge
				rs_valid_inst[l] <= (rnd() % 4 != 0) && !(stall && pend);
				drive_lane(l, kind, s);
			end
		end
		@(posedge clock);
		rs_valid_inst <= '0;
		cdb_stall     <= 1'b0;
		while (exp_q[0].size() != 0 || exp_q[1].size() != 0)
			@(posedge clock);
		$display("test %s: %0d checks, %0d errors", name, checks - chk0, errors - err0);
	endtask

	task automatic check_idle();
		checks++;
		assert (cdb_complete == 0 && prf_write_enable == 0 && cdb_exception == 0 &&
			cdb_actual_taken == 0 && rs_alu_avail == '1)
		else
		begin
			$display("control outputs not idle around reset");
			errors++;
		end
	endtask

	//////////////////////////////
	// sequence
	//////////////////////////////
	initial
	begin
		rst_n = 1'b0;
		cdb_stall = 1'b0;
		rs_valid_inst = '0;
		rs_npc = '0;
		rs_ir = '0;
		rs_opa_select = '{default: ex_pkg::REGA};
		rs_opb_select = '{default: ex_pkg::REGB};
		rs_alu_func = '{default: ex_pkg::ADDQ};
		rs_cond_branch = '0;
		rs_uncond_branch = '0;
		rs_branch_taken = '0;
		rs_pred_addr = '0;
		rs_dest_ar_idx = '0;
		rs_dest_pr_idx = '0;
		prf_pra = '0;
		prf_prb = '0;
		repeat (8)
		begin
			@(negedge clock);
			check_idle();
		end
		@(posedge clock);
		rst_n <= 1'b1;
		@(negedge clock);
		check_idle();
		$display("test %s: %0d checks, %0d errors", "reset", checks, errors);
		run_test(2, 64, "alu_funcs");
		run_test(3, 64, "operands");
		run_test(4, 64, "cond_branch");
		run_test(5, 48, "uncond_branch");
		run_test(6, 160, "backpressure");
		$display("done: %0d checks, %0d errors, %0d cycles", checks, errors, cycles);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule
